/* logic/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// number of direct-mapped lines, any power of two
`define LSU_LINES 4

// log2 of LSU_LINES, keep the two in step
`define LSU_IDX_W 2

// cacheable window 0, upper bound exclusive
`define LSU_CACHE_LO0 32'h8000_0000
`define LSU_CACHE_HI0 32'h8040_0000

// cacheable window 1, upper bound exclusive
`define LSU_CACHE_LO1 32'hA000_0000
`define LSU_CACHE_HI1 32'hC000_0000

`endif

/* logic/lsu_pkg.sv */
`include "lsu_consts.svh"

package lsu_pkg;

  // byte address and data word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // one bit per byte lane
  typedef logic [3:0] strb_t;

  // address above index and byte offset
  typedef logic [31-`LSU_IDX_W-2:0] tag_t;

  // line select
  typedef logic [`LSU_IDX_W-1:0] idx_t;

  // bit 3 marks a store, low bits follow RISC-V funct3
  typedef enum logic [3:0] {
    LB  = 4'b0000,
    LH  = 4'b0001,
    LW  = 4'b0010,
    LBU = 4'b0100,
    LHU = 4'b0101,
    SB  = 4'b1000,
    SH  = 4'b1001,
    SW  = 4'b1010
  } lsu_op_e;

  // request sequencer states
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    WAIT_RD,
    WAIT_WR
  } lsu_state_e;

endpackage

/* logic/lsu_line_if.sv */
`include "lsu_consts.svh"

interface lsu_line_if;
  import lsu_pkg::*;

  // lookup and fill, broadcast to every line
  idx_t  lk_idx;
  tag_t  lk_tag;
  logic  fill;
  word_t fill_data;
  logic  inval;

  // per-line results, each line drives its own slot
  wire [`LSU_LINES-1:0]        hit;
  wire word_t [`LSU_LINES-1:0] data;

  modport ctrl (
    output lk_idx,
    output lk_tag,
    output fill,
    output fill_data,
    output inval
  );

  modport line (
    input  lk_idx,
    input  lk_tag,
    input  fill,
    input  fill_data,
    input  inval,
    output hit,
    output data
  );

  modport sink (
    input hit,
    input data
  );

endinterface

/* logic/lsu_req_decode.sv */
`include "lsu_consts.svh"

module lsu_req_decode (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_op_e  req_op_i,
  input  lsu_pkg::addr_t    req_addr_i,
  input  lsu_pkg::word_t    req_wdata_i,
  lsu_line_if.ctrl          lk,
  input  logic              hit_any_i,
  input  logic              mem_rvalid_i,
  input  logic              mem_wready_i,
  input  lsu_pkg::word_t    mem_rdata_i,
  output logic              mem_rd_o,
  output logic              mem_wr_o,
  output lsu_pkg::addr_t    mem_addr_o,
  output lsu_pkg::word_t    mem_wdata_o,
  output lsu_pkg::strb_t    mem_wstrb_o,
  output lsu_pkg::lsu_op_e  op_o,
  output logic [1:0]        offset_o,
  output logic              busy_o,
  output logic              st_done_o
);
  import lsu_pkg::*;

  lsu_state_e state_q;
  lsu_state_e state_d;
  lsu_op_e    op_q;
  addr_t      addr_q;
  word_t      wdata_q;
  strb_t      strb_base;
  logic       is_store;
  logic       cacheable;

  assign is_store = op_q inside {SB, SH, SW};

  assign cacheable = ((addr_q >= `LSU_CACHE_LO0) && (addr_q < `LSU_CACHE_HI0)) ||
                     ((addr_q >= `LSU_CACHE_LO1) && (addr_q < `LSU_CACHE_HI1));

  // request fields are held for the whole access
  always_ff @(posedge clk)
  begin
    if (req_valid_i && state_q == IDLE)
    begin
      op_q    <= req_op_i;
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (req_valid_i)
          state_d = LOOKUP;
      LOOKUP:
        if (is_store)
          state_d = WAIT_WR;
        else if (!hit_any_i)
          state_d = WAIT_RD;
        else
          state_d = IDLE;
      WAIT_RD:
        if (mem_rvalid_i)
          state_d = IDLE;
      WAIT_WR:
        if (mem_wready_i)
          state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  // lanes before the offset shift
  always_comb
  begin
    case (op_q)
      SB:      strb_base = 4'b0001;
      SH:      strb_base = 4'b0011;
      default: strb_base = 4'b1111;
    endcase
  end

  // lookup always follows the latched address
  assign lk.lk_idx    = addr_q[`LSU_IDX_W+1:2];
  assign lk.lk_tag    = addr_q[31:`LSU_IDX_W+2];
  assign lk.fill      = (state_q == WAIT_RD) && mem_rvalid_i && cacheable;
  assign lk.fill_data = mem_rdata_i;
  // write-around, a store drops any copy of its word
  assign lk.inval     = (state_q == LOOKUP) && is_store;

  assign mem_rd_o    = (state_q == LOOKUP) && !is_store && !hit_any_i;
  assign mem_wr_o    = (state_q == LOOKUP) && is_store;
  assign mem_addr_o  = {addr_q[31:2], 2'b00};
  assign mem_wdata_o = wdata_q << {addr_q[1:0], 3'b000};
  assign mem_wstrb_o = strb_base << addr_q[1:0];

  assign op_o      = op_q;
  assign offset_o  = addr_q[1:0];
  assign busy_o    = (state_q != IDLE);
  assign st_done_o = (state_q == WAIT_WR) && mem_wready_i;

endmodule

/* logic/l1d_line.sv */
module l1d_line #(
  parameter int LINE_IDX = 0
) (
  input  logic     clk,
  input  logic     arst_n_i,
  lsu_line_if.line ln
);
  import lsu_pkg::*;

  logic  valid_q;
  tag_t  tag_q;
  word_t data_q;
  logic  sel;
  logic  tag_match;

  // slot select on the index bits only
  assign sel       = (ln.lk_idx == idx_t'(LINE_IDX));
  assign tag_match = (ln.lk_tag == tag_q);

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      valid_q <= 1'b0;
    end
    else if (ln.fill && sel)
    begin
      valid_q <= 1'b1;
    end
    else if (ln.inval && sel && tag_match)
    begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ln.fill && sel)
    begin
      tag_q  <= ln.lk_tag;
      data_q <= ln.fill_data;
    end
  end

  // only this slot of the shared result vectors
  assign ln.hit[LINE_IDX]  = valid_q && sel && tag_match;
  assign ln.data[LINE_IDX] = data_q;

endmodule

/* logic/lsu_load_align.sv */
`include "lsu_consts.svh"

module lsu_load_align (
  lsu_line_if.sink          ln,
  input  lsu_pkg::lsu_op_e  op_i,
  input  logic [1:0]        offset_i,
  input  logic              mem_rvalid_i,
  input  lsu_pkg::word_t    mem_rdata_i,
  input  logic              lookup_i,
  output logic              hit_any_o,
  output logic              rsp_valid_o,
  output lsu_pkg::word_t    rsp_data_o
);
  import lsu_pkg::*;

  word_t hit_data;
  word_t raw;
  word_t shifted;
  logic  is_load;

  assign hit_any_o = |ln.hit;
  assign is_load   = op_i inside {LB, LH, LW, LBU, LHU};

  // at most one line hits, so an OR of masked words is enough
  always_comb
  begin
    hit_data = '0;
    for (int i = 0; i < `LSU_LINES; i++)
    begin
      if (ln.hit[i])
        hit_data = hit_data | ln.data[i];
    end
  end

  // bus return wins over the cache
  assign raw     = mem_rvalid_i ? mem_rdata_i : hit_data;
  assign shifted = raw >> {offset_i, 3'b000};

  always_comb
  begin
    case (op_i)
      LB:
        rsp_data_o = {{24{shifted[7]}}, shifted[7:0]};
      LBU:
        rsp_data_o = {24'h000000, shifted[7:0]};
      LH:
        rsp_data_o = {{16{shifted[15]}}, shifted[15:0]};
      LHU:
        rsp_data_o = {16'h0000, shifted[15:0]};
      default:
        rsp_data_o = shifted;
    endcase
  end

  // a hit can only show while the request is open
  assign rsp_valid_o = (lookup_i && is_load && hit_any_o) || mem_rvalid_i;

endmodule

/* logic/lsu_top.sv */
`include "lsu_consts.svh"

module lsu_top (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_op_e  req_op_i,
  input  lsu_pkg::addr_t    req_addr_i,
  input  lsu_pkg::word_t    req_wdata_i,
  output logic              rsp_valid_o,
  output lsu_pkg::word_t    rsp_data_o,
  output logic              st_done_o,
  output logic              mem_rd_o,
  output logic              mem_wr_o,
  output lsu_pkg::addr_t    mem_addr_o,
  output lsu_pkg::word_t    mem_wdata_o,
  output lsu_pkg::strb_t    mem_wstrb_o,
  input  lsu_pkg::word_t    mem_rdata_i,
  input  logic              mem_rvalid_i,
  input  logic              mem_wready_i
);
  import lsu_pkg::*;

  lsu_op_e    op;
  logic [1:0] offset;
  logic       busy;
  logic       hit_any;

  // one lookup bus shared by all lines
  lsu_line_if lk_if ();

  lsu_req_decode req_decode_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .lk           (lk_if),
    .hit_any_i    (hit_any),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_wready_i (mem_wready_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rd_o     (mem_rd_o),
    .mem_wr_o     (mem_wr_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_wstrb_o  (mem_wstrb_o),
    .op_o         (op),
    .offset_o     (offset),
    .busy_o       (busy),
    .st_done_o    (st_done_o)
  );

  for (genvar i = 0; i < `LSU_LINES; i++)
  begin : g_line
    l1d_line #(
      .LINE_IDX (i)
    ) line_i (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .ln       (lk_if)
    );
  end

  lsu_load_align load_align_i (
    .ln           (lk_if),
    .op_i         (op),
    .offset_i     (offset),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .lookup_i     (busy),
    .hit_any_o    (hit_any),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_data_o   (rsp_data_o)
  );

endmodule

/* tests/lsu_asserts.sv */
module lsu_asserts (
  input logic clk,
  input logic arst_n_i,
  input logic req_valid_i,
  input logic busy_i,
  input logic rsp_valid_i,
  input logic st_done_i,
  input logic mem_rd_i,
  input logic mem_wr_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // no new request while an access is in flight
  a_req_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
    req_valid_i |-> !busy_i)
    else $error("request issued while the unit is busy");

  // lookup cycle answers with exactly one of hit, read or write
  a_lookup_out: assert property (@(posedge clk) disable iff (!arst_n_i)
    req_valid_i && !busy_i |=> $onehot({mem_rd_i, mem_wr_i, rsp_valid_i}))
    else $error("no single hit, read or write strobe in the cycle after a request");

  // bus strobes last one cycle
  a_rd_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
    mem_rd_i |=> !mem_rd_i)
    else $error("mem_rd_o held for more than one cycle");

  a_wr_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
    mem_wr_i |=> !mem_wr_i)
    else $error("mem_wr_o held for more than one cycle");

  a_rsp_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(rsp_valid_i && st_done_i))
    else $error("load response and store done in the same cycle");

endmodule

bind lsu_top lsu_asserts lsu_asserts_i (
  .clk         (clk),
  .arst_n_i    (arst_n_i),
  .req_valid_i (req_valid_i),
  .busy_i      (busy),
  .rsp_valid_i (rsp_valid_o),
  .st_done_i   (st_done_o),
  .mem_rd_i    (mem_rd_o),
  .mem_wr_i    (mem_wr_o)
);

/* tests/lsu_tb.sv */
module lsu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import lsu_pkg::*;

  // roughly 240 accesses of at most 6 cycles plus reset and margin
  localparam int MAX_CYCLES = 3000;
  localparam int RSP_WAIT = 16;

  logic    clk;
  logic    arst_n_i;
  logic    req_valid_i;
  lsu_op_e req_op_i;
  addr_t   req_addr_i;
  word_t   req_wdata_i;
  logic    rsp_valid_o;
  word_t   rsp_data_o;
  logic    st_done_o;
  logic    mem_rd_o;
  logic    mem_wr_o;
  addr_t   mem_addr_o;
  word_t   mem_wdata_o;
  strb_t   mem_wstrb_o;
  word_t   mem_rdata_i = '0;
  logic    mem_rvalid_i = 1'b0;
  logic    mem_wready_i = 1'b0;

  // bus side memory and reference copy by word address
  word_t  bus_mem [addr_t];
  word_t  ref_mem [addr_t];
  integer seed = 16803;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;
  int     e0;
  int     rd_wait = 0;
  int     wr_wait = 0;
  logic   rd_pend = 1'b0;
  logic   wr_pend = 1'b0;
  addr_t  rd_addr;

  // what the last access showed on the bus
  logic   saw_rd;
  logic   saw_wr;
  logic   got_rsp;
  addr_t  seen_addr;
  word_t  seen_wdata;
  strb_t  seen_strb;
  word_t  got_data;
  int     latency;

  lsu_op_e all_ops [8] = '{LB, LH, LW, LBU, LHU, SB, SH, SW};
  lsu_op_e load_ops [5] = '{LB, LBU, LH, LHU, LW};

  lsu_top lsu_top_i (.*);

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("run stopped, the tests did not end within %0d cycles", MAX_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic word_t fill_word(input addr_t wa);
    return {wa[15:0], wa[31:16]} ^ wa ^ 32'h3C5A_96E1;
  endfunction

  function automatic word_t peek(input logic from_ref, input addr_t wa);
    if (from_ref)
      return ref_mem.exists(wa) ? ref_mem[wa] : fill_word(wa);
    return bus_mem.exists(wa) ? bus_mem[wa] : fill_word(wa);
  endfunction

  function automatic int lane_bytes(input lsu_op_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  // pick the addressed byte or half and extend it
  function automatic word_t load_ref(input lsu_op_e op, input word_t w, input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    int          o;
    o = (off > 2) ? 2 : off;
    b = w[8*off +: 8];
    h = w[8*o +: 16];
    case (op)
      LB:      return {{24{b[7]}}, b};
      LBU:     return {24'h0, b};
      LH:      return {{16{h[15]}}, h};
      LHU:     return {16'h0, h};
      default: return w;
    endcase
  endfunction

  // memory model answering after 1 to 4 cycles
  always @(posedge clk)
  begin : mem_model
    word_t w;
    mem_rvalid_i <= 1'b0;
    mem_wready_i <= 1'b0;
    if (mem_rd_o)
    begin
      rd_pend = 1'b1;
      rd_addr = mem_addr_o;
      rd_wait = $unsigned($random(seed)) % 4;
    end
    if (mem_wr_o)
    begin
      w = peek(1'b0, mem_addr_o);
      for (int i = 0; i < 4; i++)
        if (mem_wstrb_o[i])
          w[8*i +: 8] = mem_wdata_o[8*i +: 8];
      bus_mem[mem_addr_o] = w;
      wr_pend = 1'b1;
      wr_wait = $unsigned($random(seed)) % 4;
    end
    if (rd_pend && rd_wait == 0)
    begin
      mem_rvalid_i <= 1'b1;
      mem_rdata_i  <= peek(1'b0, rd_addr);
      rd_pend = 1'b0;
    end
    else if (rd_pend)
      rd_wait--;
    if (wr_pend && wr_wait == 0)
    begin
      mem_wready_i <= 1'b1;
      wr_pend = 1'b0;
    end
    else if (wr_pend)
      wr_wait--;
  end

  task automatic check_val(input string sig, input word_t exp, input word_t act);
    checks++;
    if (exp !== act)
    begin
      $display("Mismatch %s: expected %h, actual %h", sig, exp, act);
      errors++;
    end
  endtask

  // one request and a wait for the strobe that matches its kind
  task automatic access(input lsu_op_e op, input addr_t addr, input word_t wdata);
    int   n;
    logic is_st;
    is_st = op inside {SB, SH, SW};
    saw_rd = 1'b0;
    saw_wr = 1'b0;
    got_rsp = 1'b0;
    n = 0;
    req_valid_i <= 1'b1;
    req_op_i    <= op;
    req_addr_i  <= addr;
    req_wdata_i <= wdata;
    @(posedge clk);
    req_valid_i <= 1'b0;
    while (!got_rsp && n < RSP_WAIT)
    begin
      @(posedge clk);
      n++;
      if (mem_rd_o)
      begin
        saw_rd = 1'b1;
        seen_addr = mem_addr_o;
      end
      if (mem_wr_o)
      begin
        saw_wr = 1'b1;
        seen_addr = mem_addr_o;
        seen_wdata = mem_wdata_o;
        seen_strb = mem_wstrb_o;
      end
      if (is_st ? rsp_valid_o : st_done_o)
      begin
        $display("%s at %h raised the wrong response strobe", op.name(), addr);
        errors++;
      end
      if (is_st ? st_done_o : rsp_valid_o)
      begin
        got_rsp = 1'b1;
        got_data = rsp_data_o;
        latency = n;
      end
    end
    if (!got_rsp)
    begin
      $display("no response to %s at %h within %0d cycles", op.name(), addr, RSP_WAIT);
      errors++;
    end
  endtask

  // miss of 1 expects a bus read and 0 a hit, anything else allows either
  task automatic load_check(input lsu_op_e op, input addr_t addr, input int miss);
    addr_t wa;
    wa = {addr[31:2], 2'b00};
    access(op, addr, '0);
    if (got_rsp)
    begin
      check_val("rsp_data_o", load_ref(op, peek(1'b1, wa), addr[1:0]), got_data);
      if (miss == 1)
        check_val("mem_rd_o", 1, saw_rd);
      if (miss == 1 && saw_rd)
        check_val("mem_addr_o", wa, seen_addr);
      if (miss == 0)
      begin
        check_val("mem_rd_o", 0, saw_rd);
        check_val("rsp_valid_o cycle", 1, latency);
      end
    end
  endtask

  task automatic store_check(input lsu_op_e op, input addr_t addr, input word_t wdata);
    addr_t      wa;
    logic [1:0] off;
    strb_t      es;
    word_t      mask;
    word_t      ed;
    wa = {addr[31:2], 2'b00};
    off = addr[1:0];
    es = '0;
    mask = '0;
    ed = '0;
    for (int i = 0; i < lane_bytes(op); i++)
    begin
      es[off + i] = 1'b1;
      mask[8*(off + i) +: 8] = 8'hFF;
      ed[8*(off + i) +: 8] = wdata[8*i +: 8];
    end
    ref_mem[wa] = (peek(1'b1, wa) & ~mask) | ed;
    access(op, addr, wdata);
    if (got_rsp)
      check_val("mem_wr_o", 1, saw_wr);
    if (got_rsp && saw_wr)
    begin
      check_val("mem_addr_o", wa, seen_addr);
      check_val("mem_wstrb_o", es, seen_strb);
      check_val("mem_wdata_o", ed, seen_wdata & mask);
    end
  endtask

  task automatic idle_after_reset();
    repeat (6)
    begin
      @(posedge clk);
      checks++;
      if (rsp_valid_o || st_done_o || mem_rd_o || mem_wr_o)
      begin
        $display("an output went high before any request was made");
        errors++;
      end
    end
  endtask

  task automatic miss_loads();
    int n;
    n = 0;
    foreach (load_ops[k])
      for (int off = 0; off < 4; off++)
        if (off + lane_bytes(load_ops[k]) <= 4)
        begin
          load_check(load_ops[k], 32'h8000_0100 + n * 16 + off, 1);
          n++;
        end
  endtask

  task automatic hit_loads();
    load_check(LW, 32'h8000_0204, 1);
    load_check(LW, 32'h8000_0204, 0);
    load_check(LBU, 32'h8000_0207, 0);
    load_check(LH, 32'h8000_0206, 0);
    load_check(LW, 32'hA000_0010, 1);
    load_check(LB, 32'hA000_0011, 0);
  endtask

  task automatic store_invalidate();
    lsu_op_e    st_ops [3] = '{SB, SH, SW};
    logic [1:0] offs [3] = '{2'd3, 2'd1, 2'd0};
    addr_t      wa;
    for (int k = 0; k < 3; k++)
    begin
      wa = 32'hA000_0040 + k * 4;
      load_check(LW, wa, 1);
      load_check(LW, wa, 0);
      store_check(st_ops[k], wa + offs[k], 32'hC0DE_5A00 + k);
      // the store dropped the line so this reads the bus again
      load_check(LW, wa, 1);
    end
  endtask

  task automatic uncached_loads();
    repeat (2)
    begin
      load_check(LW, 32'h4000_0020, 1);
      load_check(LW, 32'h8040_0000, 1);
      load_check(LHU, 32'h7FFF_FFFE, 1);
    end
  endtask

  task automatic random_mix();
    addr_t       bases [4] = '{32'h8000_0000, 32'h803F_FFF0, 32'hA000_0000, 32'h4000_0000};
    logic [31:0] r;
    addr_t       addr;
    lsu_op_e     op;
    repeat (200)
    begin
      r = $random(seed);
      op = all_ops[r[8:6]];
      addr = bases[r[1:0]] + {r[3:2], 2'b00} + r[5:4];
      if (lane_bytes(op) == 2)
        addr[0] = 1'b0;
      if (lane_bytes(op) == 4)
        addr[1:0] = 2'b00;
      if (op inside {SB, SH, SW})
        store_check(op, addr, $random(seed));
      else
        load_check(op, addr, -1);
    end
  endtask

  initial
  begin
    clk = 1'b0;
    arst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_op_i = LW;
    req_addr_i = '0;
    req_wdata_i = '0;
    repeat (16) @(posedge clk);
    arst_n_i <= 1'b1;
    e0 = errors;
    idle_after_reset();
    $display("idle after reset: %0d errors", errors - e0);
    e0 = errors;
    miss_loads();
    $display("load misses: %0d errors", errors - e0);
    e0 = errors;
    hit_loads();
    $display("load hits: %0d errors", errors - e0);
    e0 = errors;
    store_invalidate();
    $display("stores: %0d errors", errors - e0);
    e0 = errors;
    uncached_loads();
    $display("uncached loads: %0d errors", errors - e0);
    e0 = errors;
    random_mix();
    $display("random mix: %0d errors", errors - e0);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* src.f */
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_line_if.sv
logic/lsu_req_decode.sv
logic/l1d_line.sv
logic/lsu_load_align.sv
logic/lsu_top.sv
tests/lsu_asserts.sv
tests/lsu_tb.sv
